/* all.f */
+incdir+logic
logic/mips_pkg.sv
logic/instr_decode.sv
logic/alu.sv
logic/hi_lo_unit.sv
logic/branch_compare.sv
logic/exec_stage.sv
verif/exec_stage_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary
TOP      := exec_stage_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED

HEADERS := logic/mips_settings.svh
SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/exec_stage_tb.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module exec_stage_tb import mips_pkg::*; ();

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] instr;
        logic [`DATA_WIDTH-1:0] rs;
        logic [`DATA_WIDTH-1:0] rt;
        logic                   exec;
        logic [`DATA_WIDTH-1:0] result;
        logic [2:0]             flags;  // Zero, positive, negative.
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   fetch;
    logic                   exec1;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`DATA_WIDTH-1:0] rs_value;
    logic [`DATA_WIDTH-1:0] rt_value;
    logic [`DATA_WIDTH-1:0] result;
    logic                   zero;
    logic                   positive;
    logic                   negative;

    row_t rows[$];
    int   cycle_count = 0;
    int   cycle_limit = 1000;

    exec_stage dut_i (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetch),
        .exec1    (exec1),
        .instr    (instr),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .result   (result),
        .zero     (zero),
        .positive (positive),
        .negative (negative)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the table.", cycle_count);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    function automatic logic [`DATA_WIDTH-1:0] r_type(input logic [5:0] funct,
                                                      input logic [4:0] shamt);
        return {6'h00, 15'h0000, shamt, funct};
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] i_type(input logic [5:0] opcode,
                                                      input logic [15:0] imm);
        return {opcode, 10'h000, imm};
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] regimm(input logic [4:0] rt_sel);
        return {6'h01, 5'h00, rt_sel, 16'h0000};  // The branch type sits in the rt field.
    endfunction

    task automatic add_row(input logic [`DATA_WIDTH-1:0] row_instr,
                           input logic [`DATA_WIDTH-1:0] rs,
                           input logic [`DATA_WIDTH-1:0] rt,
                           input logic                   exec,
                           input logic [`DATA_WIDTH-1:0] exp_result,
                           input logic [2:0]             exp_flags);
        row_t row;
        row = '{row_instr, rs, rt, exec, exp_result, exp_flags};
        rows.push_back(row);
    endtask

    task automatic check_word(input string name,
                              input logic [`DATA_WIDTH-1:0] expected,
                              input logic [`DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    task automatic check_flags(input logic [2:0] expected, input logic [2:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t zero/positive/negative expected=%b actual=%b",
                     $time, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Mismatch on the branch flags.");
        end
    endtask

    initial begin
        logic [`DATA_WIDTH-1:0] x;
        logic [`DATA_WIDTH-1:0] y;

        void'($urandom(70));
        reset    = 1'b1;
        fetch    = 1'b0;
        exec1    = 1'b0;
        instr    = '0;
        rs_value = '0;
        rt_value = '0;

        // HI and LO straight out of reset.
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_0000, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_0000, 3'b000);
        add_row(r_type(6'h21, 5'd0), 32'h0000_0005, 32'h0000_0007, 1'b0, 32'h0000_000c, 3'b000);
        add_row(r_type(6'h20, 5'd0), 32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0000, 3'b000);
        add_row(r_type(6'h23, 5'd0), 32'h0000_0003, 32'h0000_0005, 1'b0, 32'hffff_fffe, 3'b000);
        add_row(r_type(6'h24, 5'd0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 1'b0, 32'h00f0_0f00, 3'b000);
        add_row(r_type(6'h25, 5'd0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 1'b0, 32'hfff0_fff0, 3'b000);
        add_row(r_type(6'h26, 5'd0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 1'b0, 32'hff00_f0f0, 3'b000);
        add_row(r_type(6'h00, 5'd4), 32'h0, 32'h0000_00f1, 1'b0, 32'h0000_0f10, 3'b000);
        add_row(r_type(6'h02, 5'd4), 32'h0, 32'h8000_0010, 1'b0, 32'h0800_0001, 3'b000);
        add_row(r_type(6'h03, 5'd4), 32'h0, 32'h8000_0010, 1'b0, 32'hf800_0001, 3'b000);
        add_row(r_type(6'h04, 5'd0), 32'h0000_0024, 32'h0000_0001, 1'b0, 32'h0000_0010, 3'b000);
        add_row(r_type(6'h06, 5'd0), 32'h0000_0008, 32'hff00_0000, 1'b0, 32'h00ff_0000, 3'b000);
        add_row(r_type(6'h07, 5'd0), 32'h0000_0008, 32'hff00_0000, 1'b0, 32'hffff_0000, 3'b000);
        add_row(r_type(6'h2a, 5'd0), 32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0001, 3'b000);
        add_row(r_type(6'h2b, 5'd0), 32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0000, 3'b000);
        add_row(i_type(6'h08, 16'hfffe), 32'h0000_000a, 32'h0, 1'b0, 32'h0000_0008, 3'b000);
        add_row(i_type(6'h09, 16'h8000), 32'h0000_0000, 32'h0, 1'b0, 32'hffff_8000, 3'b000);
        add_row(i_type(6'h0a, 16'h0001), 32'hffff_fffe, 32'h0, 1'b0, 32'h0000_0001, 3'b000);
        add_row(i_type(6'h0b, 16'hffff), 32'h0001_0000, 32'h0, 1'b0, 32'h0000_0001, 3'b000);
        add_row(i_type(6'h0c, 16'hff0f), 32'hffff_ffff, 32'h0, 1'b0, 32'h0000_ff0f, 3'b000);
        add_row(i_type(6'h0d, 16'h8001), 32'h1234_0000, 32'h0, 1'b0, 32'h1234_8001, 3'b000);
        add_row(i_type(6'h0e, 16'hffff), 32'hffff_00ff, 32'h0, 1'b0, 32'hffff_ff00, 3'b000);
        add_row(i_type(6'h0f, 16'habcd), 32'h0000_1111, 32'h0, 1'b0, 32'habcd_0000, 3'b000);
        add_row(i_type(6'h23, 16'hfffc), 32'h0000_1000, 32'h0, 1'b0, 32'h0000_0ffc, 3'b000);
        add_row(i_type(6'h2b, 16'h0010), 32'h0000_1000, 32'h0, 1'b0, 32'h0000_1010, 3'b000);
        // Each HI/LO writer is followed by MFHI and MFLO.
        add_row(r_type(6'h18, 5'd0), 32'hffff_fffe, 32'h0000_0003, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_ffff, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_fffa, 3'b000);
        add_row(r_type(6'h19, 5'd0), 32'hffff_ffff, 32'h0000_0002, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_0001, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_fffe, 3'b000);
        add_row(r_type(6'h1a, 5'd0), 32'hffff_fff9, 32'h0000_0002, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_ffff, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_fffd, 3'b000);
        add_row(r_type(6'h1b, 5'd0), 32'hffff_fff9, 32'h0000_0002, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_0001, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'h7fff_fffc, 3'b000);
        add_row(r_type(6'h1a, 5'd0), 32'h1234_5678, 32'h0000_0000, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h1234_5678, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_ffff, 3'b000);
        add_row(r_type(6'h1a, 5'd0), 32'h8000_0000, 32'hffff_ffff, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_0000, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'h8000_0000, 3'b000);
        add_row(r_type(6'h1b, 5'd0), 32'h0000_00aa, 32'h0000_0000, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_00aa, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_ffff, 3'b000);
        // Moves without exec1 must leave HI and LO alone.
        add_row(r_type(6'h11, 5'd0), 32'h5555_aaaa, 32'h0, 1'b0, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h0000_00aa, 3'b000);
        add_row(r_type(6'h11, 5'd0), 32'h5555_aaaa, 32'h0, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h10, 5'd0), 32'h0, 32'h0, 1'b0, 32'h5555_aaaa, 3'b000);
        add_row(r_type(6'h13, 5'd0), 32'h1357_9bdf, 32'h0, 1'b0, 32'h0, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'hffff_ffff, 3'b000);
        add_row(r_type(6'h13, 5'd0), 32'h1357_9bdf, 32'h0, 1'b1, 32'h0, 3'b000);
        add_row(r_type(6'h12, 5'd0), 32'h0, 32'h0, 1'b0, 32'h1357_9bdf, 3'b000);
        add_row(i_type(6'h04, 16'h0010), 32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0, 3'b100);
        add_row(i_type(6'h05, 16'h0010), 32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0, 3'b001);
        add_row(i_type(6'h04, 16'h0010), 32'h0000_0007, 32'h0000_0003, 1'b0, 32'h0, 3'b010);
        add_row(regimm(5'h01), 32'h0000_0000, 32'h0000_0004, 1'b0, 32'h0, 3'b100);
        add_row(regimm(5'h00), 32'h8000_0000, 32'h0000_0004, 1'b0, 32'h0, 3'b001);
        add_row(regimm(5'h11), 32'h0000_0009, 32'h0000_0000, 1'b0, 32'h0, 3'b010);
        add_row(regimm(5'h10), 32'h0000_0000, 32'hffff_ffff, 1'b0, 32'h0, 3'b100);
        add_row(i_type(6'h07, 16'h0000), 32'hffff_fff0, 32'h0, 1'b0, 32'h0, 3'b001);
        add_row(i_type(6'h06, 16'h0000), 32'h0000_0001, 32'h0, 1'b0, 32'h0, 3'b010);
        // Undecodable words give no result and no flags.
        add_row(i_type(6'h3f, 16'h1234), 32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0, 3'b000);
        add_row(r_type(6'h3f, 5'd3), 32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0, 3'b000);
        add_row(regimm(5'h05), 32'h8000_0000, 32'h0, 1'b0, 32'h0, 3'b000);
        for (int k = 0; k < 4; k++) begin
            x = $urandom;
            y = $urandom;
            add_row(r_type(6'h21, 5'd0), x, y, 1'b0, x + y, 3'b000);
            add_row(r_type(6'h23, 5'd0), x, y, 1'b0, x - y, 3'b000);
            add_row(r_type(6'h26, 5'd0), x, y, 1'b0, x ^ y, 3'b000);
            add_row(r_type(6'h2b, 5'd0), x, y, 1'b0, {{(`DATA_WIDTH-1){1'b0}}, x < y}, 3'b000);
        end
        cycle_limit = 8 + 4 * rows.size() + 20;

        repeat (8) @(posedge clk);
        #2 reset = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #2;
            fetch = 1'b1;
            instr = rows[i].instr;
            @(posedge clk);
            #2;
            fetch    = 1'b0;
            rs_value = rows[i].rs;
            rt_value = rows[i].rt;
            @(posedge clk);  // Nothing clocks state here, so the outputs are settled.
            check_word("result", rows[i].result, result);
            check_flags(rows[i].flags, {zero, positive, negative});
            if (rows[i].exec) begin
                #2 exec1 = 1'b1;
                @(posedge clk);
                #2 exec1 = 1'b0;
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module exec_stage import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch,
    input  logic                   exec1,
    input  logic [`DATA_WIDTH-1:0] instr,
    input  logic [`DATA_WIDTH-1:0] rs_value,
    input  logic [`DATA_WIDTH-1:0] rt_value,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero,
    output logic                   positive,
    output logic                   negative
);

    alu_op_e                 op;
    logic [`SHAMT_WIDTH-1:0] sa;
    logic [`DATA_WIDTH-1:0]  a;
    logic [`DATA_WIDTH-1:0]  b;
    logic [`DATA_WIDTH-1:0]  hi;
    logic [`DATA_WIDTH-1:0]  lo;

    instr_decode instr_decode_i (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetch),
        .instr    (instr),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .op       (op),
        .sa       (sa),
        .a        (a),
        .b        (b)
    );

    alu alu_i (
        .op     (op),
        .sa     (sa),
        .a      (a),
        .b      (b),
        .hi     (hi),
        .lo     (lo),
        .result (result)
    );

    hi_lo_unit hi_lo_unit_i (
        .clk   (clk),
        .reset (reset),
        .exec1 (exec1),
        .op    (op),
        .a     (a),
        .b     (b),
        .hi    (hi),
        .lo    (lo)
    );

    branch_compare branch_compare_i (
        .op       (op),
        .a        (a),
        .b        (b),
        .zero     (zero),
        .positive (positive),
        .negative (negative)
    );

endmodule

/* logic/branch_compare.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module branch_compare import mips_pkg::*; (
    input  alu_op_e                op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic                   zero,
    output logic                   positive,
    output logic                   negative
);

    logic signed [`DATA_WIDTH-1:0] a_s;
    logic signed [`DATA_WIDTH-1:0] b_s;

    assign a_s = a;
    assign b_s = b;

    always_comb begin
        zero     = 1'b0;
        positive = 1'b0;
        negative = 1'b0;
        case (op)
            op_bgez, op_bgezal, op_bgtz, op_blez, op_bltz, op_bltzal: begin
                zero     = (a_s == 0);  // Sign of rs alone.
                positive = (a_s > 0);
                negative = (a_s < 0);
            end
            op_beq, op_bne: begin
                zero     = (a_s == b_s);
                positive = (a_s > b_s);
                negative = (a_s < b_s);
            end
            default: ;
        endcase
    end

endmodule

/* logic/hi_lo_unit.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module hi_lo_unit import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exec1,
    input  alu_op_e                op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] hi,
    output logic [`DATA_WIDTH-1:0] lo
);

    logic signed [`DATA_WIDTH-1:0]   a_s;
    logic signed [`DATA_WIDTH-1:0]   b_s;
    logic [2*`DATA_WIDTH-1:0]        prod_s;
    logic [2*`DATA_WIDTH-1:0]        prod_u;
    logic                            div_zero;
    logic                            div_ovf;
    logic signed [`DATA_WIDTH-1:0]   divisor_s;
    logic [`DATA_WIDTH-1:0]          divisor_u;
    logic [`DATA_WIDTH-1:0]          quot_s;
    logic [`DATA_WIDTH-1:0]          rem_s;
    logic [`DATA_WIDTH-1:0]          quot_u;
    logic [`DATA_WIDTH-1:0]          rem_u;
    logic [`DATA_WIDTH-1:0]          hi_next;
    logic [`DATA_WIDTH-1:0]          lo_next;
    logic                            write_hi;
    logic                            write_lo;

    assign a_s    = a;
    assign b_s    = b;
    assign prod_s = a_s * b_s;
    assign prod_u = a * b;

    assign div_zero = (b == '0);
    assign div_ovf  = (a == {1'b1, {(`DATA_WIDTH-1){1'b0}}}) && (b == '1);

    // Dividing by one in the corner cases keeps the divider defined.
    // For the signed overflow it already gives LO as a and HI as zero.
    assign divisor_s = (div_zero || div_ovf) ? 1 : b_s;
    assign divisor_u = div_zero ? 1 : b;
    assign quot_s    = a_s / divisor_s;
    assign rem_s     = a_s % divisor_s;  // Takes the sign of the dividend.
    assign quot_u    = a / divisor_u;
    assign rem_u     = a % divisor_u;

    always_comb begin
        hi_next  = hi;
        lo_next  = lo;
        write_hi = 1'b1;
        write_lo = 1'b1;
        case (op)
            op_mult: {hi_next, lo_next} = prod_s;
            op_multu: {hi_next, lo_next} = prod_u;
            op_div: begin
                lo_next = div_zero ? '1 : quot_s;
                hi_next = div_zero ? a : rem_s;
            end
            op_divu: begin
                lo_next = div_zero ? '1 : quot_u;
                hi_next = div_zero ? a : rem_u;
            end
            op_mthi: begin
                hi_next  = a;
                write_lo = 1'b0;
            end
            op_mtlo: begin
                lo_next  = a;
                write_hi = 1'b0;
            end
            default: begin
                write_hi = 1'b0;
                write_lo = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (exec1) begin
            if (write_hi) begin
                hi <= hi_next;
            end
            if (write_lo) begin
                lo <= lo_next;
            end
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module alu import mips_pkg::*; (
    input  alu_op_e                 op,
    input  logic [`SHAMT_WIDTH-1:0] sa,
    input  logic [`DATA_WIDTH-1:0]  a,
    input  logic [`DATA_WIDTH-1:0]  b,
    input  logic [`DATA_WIDTH-1:0]  hi,
    input  logic [`DATA_WIDTH-1:0]  lo,
    output logic [`DATA_WIDTH-1:0]  result
);

    logic signed [`DATA_WIDTH-1:0]  a_s;
    logic signed [`DATA_WIDTH-1:0]  b_s;
    logic [`SHAMT_WIDTH-1:0]        var_sa;

    assign a_s    = a;
    assign b_s    = b;
    assign var_sa = a[`SHAMT_WIDTH-1:0];  // Variable shifts take the low bits of rs.

    always_comb begin
        result = '0;
        case (op)
            // Overflow traps are not modelled, so ADD and ADDI wrap like ADDU.
            // LUI arrives with a cleared, so the sum is the shifted immediate.
            op_add, op_addi, op_addiu, op_addu, op_lui,
            op_lb, op_lbu, op_lh, op_lhu, op_lw,
            op_sb, op_sh, op_sw: result = a + b;
            op_subu: result = a - b;
            op_and, op_andi: result = a & b;
            op_or, op_ori: result = a | b;
            op_xor, op_xori: result = a ^ b;
            op_sll: result = b << sa;
            op_srl: result = b >> sa;
            op_sra: result = b_s >>> sa;
            op_sllv: result = b << var_sa;
            op_srlv: result = b >> var_sa;
            op_srav: result = b_s >>> var_sa;
            op_slt, op_slti: result = {{(`DATA_WIDTH-1){1'b0}}, a_s < b_s};
            op_sltu, op_sltiu: result = {{(`DATA_WIDTH-1){1'b0}}, a < b};
            op_mfhi: result = hi;
            op_mflo: result = lo;
            default: result = '0;  // HI/LO writers, branches and op_none.
        endcase
    end

endmodule

/* logic/instr_decode.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module instr_decode import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch,
    input  logic [`DATA_WIDTH-1:0]  instr,
    input  logic [`DATA_WIDTH-1:0]  rs_value,
    input  logic [`DATA_WIDTH-1:0]  rt_value,
    output alu_op_e                 op,
    output logic [`SHAMT_WIDTH-1:0] sa,
    output logic [`DATA_WIDTH-1:0]  a,
    output logic [`DATA_WIDTH-1:0]  b
);

    logic [`DATA_WIDTH-1:0] instr_q;
    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [4:0]             rt_field;
    logic [15:0]            imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_q <= '0;  // Reads back as SLL with zero shift.
        end else if (fetch) begin
            instr_q <= instr;
        end
    end

    assign opcode   = instr_q[31:26];
    assign funct    = instr_q[5:0];
    assign rt_field = instr_q[20:16];
    assign imm      = instr_q[15:0];
    assign sa       = instr_q[10:6];

    always_comb begin
        op = op_none;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h00: op = op_sll;
                    6'h02: op = op_srl;
                    6'h03: op = op_sra;
                    6'h04: op = op_sllv;
                    6'h06: op = op_srlv;
                    6'h07: op = op_srav;
                    6'h10: op = op_mfhi;
                    6'h11: op = op_mthi;
                    6'h12: op = op_mflo;
                    6'h13: op = op_mtlo;
                    6'h18: op = op_mult;
                    6'h19: op = op_multu;
                    6'h1a: op = op_div;
                    6'h1b: op = op_divu;
                    6'h20: op = op_add;
                    6'h21: op = op_addu;
                    6'h23: op = op_subu;
                    6'h24: op = op_and;
                    6'h25: op = op_or;
                    6'h26: op = op_xor;
                    6'h2a: op = op_slt;
                    6'h2b: op = op_sltu;
                    default: op = op_none;
                endcase
            end
            6'h01: begin
                case (rt_field)  // REGIMM selects the branch by its rt field.
                    5'h00: op = op_bltz;
                    5'h01: op = op_bgez;
                    5'h10: op = op_bltzal;
                    5'h11: op = op_bgezal;
                    default: op = op_none;
                endcase
            end
            6'h04: op = op_beq;
            6'h05: op = op_bne;
            6'h06: op = op_blez;
            6'h07: op = op_bgtz;
            6'h08: op = op_addi;
            6'h09: op = op_addiu;
            6'h0a: op = op_slti;
            6'h0b: op = op_sltiu;
            6'h0c: op = op_andi;
            6'h0d: op = op_ori;
            6'h0e: op = op_xori;
            6'h0f: op = op_lui;
            6'h20: op = op_lb;
            6'h21: op = op_lh;
            6'h23: op = op_lw;
            6'h24: op = op_lbu;
            6'h25: op = op_lhu;
            6'h28: op = op_sb;
            6'h29: op = op_sh;
            6'h2b: op = op_sw;
            default: op = op_none;
        endcase
    end

    always_comb begin
        a = rs_value;
        b = rt_value;
        case (op)
            op_addi, op_addiu, op_slti, op_sltiu,
            op_lb, op_lbu, op_lh, op_lhu, op_lw,
            op_sb, op_sh, op_sw: b = {{(`DATA_WIDTH-16){imm[15]}}, imm};
            op_andi, op_ori, op_xori: b = {{(`DATA_WIDTH-16){1'b0}}, imm};
            op_lui: begin
                a = '0;
                b = {imm, 16'h0000};
            end
            default: ;
        endcase
    end

endmodule

/* logic/mips_pkg.sv */
`include "mips_settings.svh"

package mips_pkg;

    typedef enum logic [`OP_WIDTH-1:0] {
        op_none   = 0,  // Unrecognized instruction.
        op_add    = 1,
        op_addi   = 2,
        op_addiu  = 3,
        op_addu   = 4,
        op_and    = 5,
        op_andi   = 6,
        op_div    = 7,
        op_divu   = 8,
        op_mfhi   = 9,
        op_mflo   = 10,
        op_mthi   = 11,
        op_mtlo   = 12,
        op_mult   = 13,
        op_multu  = 14,
        op_or     = 15,
        op_ori    = 16,
        op_sll    = 17,
        op_sllv   = 18,
        op_slt    = 19,
        op_slti   = 20,
        op_sltiu  = 21,
        op_sltu   = 22,
        op_sra    = 23,
        op_srav   = 24,
        op_srl    = 25,
        op_srlv   = 26,
        op_subu   = 27,
        op_xor    = 28,
        op_xori   = 29,
        op_beq    = 30,
        op_bgez   = 31,
        op_bgezal = 32,
        op_bgtz   = 33,
        op_blez   = 34,
        op_bltz   = 35,
        op_bltzal = 36,
        op_bne    = 37,
        op_lb     = 42,  // Codes 38 to 41 belong to the jumps.
        op_lbu    = 43,
        op_lh     = 44,
        op_lhu    = 45,
        op_lui    = 46,
        op_lw     = 47,
        op_sb     = 50,  // Codes 48 and 49 belong to LWL and LWR.
        op_sh     = 51,
        op_sw     = 52
    } alu_op_e;

endpackage

/* logic/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// One machine word, used for operands, results, HI and LO.
`define DATA_WIDTH 32

// Shift amount field of an R-type instruction.
`define SHAMT_WIDTH 5

// Width of the decoded operation code.
`define OP_WIDTH 7

`endif
